//--- compile.f
+incdir+include
design/fetch_pkg.sv
design/fetch_pc.sv
design/icache.sv
design/instr_memory.sv
design/fetch_output.sv
design/fetch_top.sv
test/fetch_tb.sv

//--- design/fetch_output.sv
// Fetch output stage
// Picks the addressed instruction out of the 64-bit line and
// registers it with its pc as a one-cycle packet

module fetch_output (
    input  logic                     clock,
    input  logic                     reset,
    input  fetch_pkg::addr_t         pc,
    input  fetch_pkg::line_t         line,
    input  logic                     hit,
    output fetch_pkg::fetch_packet_t packet,
    output logic                     packet_valid
);

    fetch_pkg::instr_t word;

    // Bit 2 selects the upper half of the line
    assign word = pc[2] ? line[63:32] : line[31:0];

    ////////////////////////////////////////////////////////////
    // Packet register
    ////////////////////////////////////////////////////////////

    // Valid is a pulse, one per hit
    always_ff @(posedge clock) begin
        if (reset) begin
            packet_valid <= 1'b0;
        end else begin
            packet_valid <= hit;
        end
    end

    // Payload only loads on a hit
    always_ff @(posedge clock) begin
        if (hit) begin
            packet.pc          <= pc;
            packet.instruction <= word;
        end
    end

endmodule

//--- design/fetch_pc.sv
// Program counter
// Holds the fetch address, steps one word on every cache hit and
// takes the branch target when a redirect arrives

`include "fetch_defs.svh"

module fetch_pc (
    input  logic             clock,
    input  logic             reset,
    input  logic             hit,          // Current pc was served this cycle
    input  logic             redirect,     // Branch taken pulse
    input  fetch_pkg::addr_t redirect_pc,  // Branch target
    output fetch_pkg::addr_t pc
);

    ////////////////////////////////////////////////////////////
    // Next address
    ////////////////////////////////////////////////////////////

    fetch_pkg::addr_t pc_reg;
    fetch_pkg::addr_t pc_next;
    fetch_pkg::addr_t pc_plus_four;

    assign pc_plus_four = pc_reg + fetch_pkg::addr_t'(4);   // One instruction ahead

    always_comb begin
        // Redirect has priority, the hit word is already on its way out
        if (redirect) begin
            pc_next = redirect_pc;
        end else if (hit) begin
            pc_next = pc_plus_four;
        end else begin
            pc_next = pc_reg;       // Stall on a miss
        end
    end

    ////////////////////////////////////////////////////////////
    // Register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            pc_reg <= `FETCH_RESET_PC;
        end else begin
            pc_reg <= pc_next;
        end
    end

    assign pc = pc_reg;

endmodule

//--- design/fetch_pkg.sv
// Fetch path types
// Vector typedefs, bus command and cache state enums, and the
// structs passed between PC, cache, memory and output stage

`include "fetch_defs.svh"

package fetch_pkg;

    ////////////////////////////////////////////////////////////
    // Plain vectors
    ////////////////////////////////////////////////////////////

    typedef logic [`FETCH_ADDR_BITS-1:0]    addr_t;     // PC or byte address
    typedef logic [63:0]                    line_t;     // One memory or cache line
    typedef logic [31:0]                    instr_t;    // One instruction word
    typedef logic [`FETCH_MEM_TAG_BITS-1:0] mem_tag_t;  // Zero means no transaction

    // Cache address split, 3 offset bits inside a line
    typedef logic [$clog2(`FETCH_CACHE_LINES)-1:0] cache_index_t;
    typedef logic [`FETCH_MEM_ADDR_BITS-$clog2(`FETCH_CACHE_LINES)-4:0] cache_tag_t;

    ////////////////////////////////////////////////////////////
    // Enums
    ////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        bus_none = 2'd0,
        bus_load = 2'd1
    } bus_cmd_e;

    // Miss handling of the blocking cache
    typedef enum logic [1:0] {
        cache_idle,         // Hit, or nothing pending
        cache_requesting,   // Load command out, no tag granted yet
        cache_waiting       // Tag held, waiting for the line
    } cache_state_e;

    ////////////////////////////////////////////////////////////
    // Structs
    ////////////////////////////////////////////////////////////

    typedef struct packed {
        bus_cmd_e command;
        addr_t    addr;         // Line aligned
    } mem_request_t;

    typedef struct packed {
        mem_tag_t grant_tag;    // Same cycle as the command
        mem_tag_t return_tag;   // Nonzero only when data arrives
        line_t    return_data;
    } mem_reply_t;

    typedef struct packed {
        addr_t  pc;
        instr_t instruction;
    } fetch_packet_t;

endpackage

//--- design/fetch_top.sv
// Fetch path top level
// Program counter, instruction cache, tagged instruction memory
// and output register wired together

module fetch_top (
    input  logic                     clock,
    input  logic                     reset,
    input  logic                     redirect,      // Branch pulse
    input  fetch_pkg::addr_t         redirect_pc,
    input  logic                     mem_busy,      // Higher priority requester
    input  logic                     load_write,    // Program preload
    input  fetch_pkg::addr_t         load_addr,
    input  fetch_pkg::line_t         load_data,
    output fetch_pkg::fetch_packet_t packet,
    output logic                     packet_valid
);

    fetch_pkg::addr_t        pc;
    fetch_pkg::line_t        line;
    logic                    hit;
    fetch_pkg::mem_request_t mem_request;   // Cache to memory
    fetch_pkg::mem_reply_t   mem_reply;     // Memory to cache

    fetch_pc fetch_pc_inst (
        .clock       (clock),
        .reset       (reset),
        .hit         (hit),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc          (pc)
    );

    icache icache_inst (
        .clock       (clock),
        .reset       (reset),
        .pc          (pc),
        .mem_reply   (mem_reply),
        .mem_request (mem_request),
        .line        (line),
        .hit         (hit)
    );

    instr_memory instr_memory_inst (
        .clock       (clock),
        .reset       (reset),
        .mem_request (mem_request),
        .mem_busy    (mem_busy),
        .load_write  (load_write),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .mem_reply   (mem_reply)
    );

    fetch_output fetch_output_inst (
        .clock        (clock),
        .reset        (reset),
        .pc           (pc),
        .line         (line),
        .hit          (hit),
        .packet       (packet),
        .packet_valid (packet_valid)
    );

endmodule

//--- design/icache.sv
// Instruction cache
// Blocking direct-mapped cache with one 64-bit line per entry
// Tracks a single memory transaction tag and fills the line when the
// matching tag comes back; an address change abandons the request

`include "fetch_defs.svh"

module icache (
    input  logic                    clock,
    input  logic                    reset,
    input  fetch_pkg::addr_t        pc,
    input  fetch_pkg::mem_reply_t   mem_reply,
    output fetch_pkg::mem_request_t mem_request,
    output fetch_pkg::line_t        line,
    output logic                    hit
);

    localparam int cache_lines = `FETCH_CACHE_LINES;

    // One cache entry
    typedef struct packed {
        fetch_pkg::line_t      data;
        fetch_pkg::cache_tag_t tag;
        logic                  valid;
    } entry_t;

    entry_t entries [cache_lines];

    fetch_pkg::cache_tag_t   cur_tag, last_tag;      // Cache tags, not memory tags
    fetch_pkg::cache_index_t cur_index, last_index;

    fetch_pkg::cache_state_e state, state_next;
    fetch_pkg::mem_tag_t     mem_tag, mem_tag_next;  // Outstanding transaction

    logic changed_addr;
    logic got_data;

    ////////////////////////////////////////////////////////////
    // Lookup
    ////////////////////////////////////////////////////////////

    // Tag is bits 15..8, index 7..3, low three are the line offset
    assign {cur_tag, cur_index} = pc[`FETCH_MEM_ADDR_BITS-1:3];

    assign line = entries[cur_index].data;
    assign hit  = entries[cur_index].valid && (entries[cur_index].tag == cur_tag);

    // New address this cycle, restarts miss handling
    assign changed_addr = (cur_index != last_index) || (cur_tag != last_tag);

    // Return for our own tag; mem_tag is nonzero while waiting
    assign got_data = (state == fetch_pkg::cache_waiting) && !changed_addr &&
                      (mem_reply.return_tag == mem_tag);

    ////////////////////////////////////////////////////////////
    // Memory request
    ////////////////////////////////////////////////////////////

    // Repeat the load until a tag is granted or the pc moves
    assign mem_request.command = ((state == fetch_pkg::cache_requesting) && !changed_addr) ?
                                 fetch_pkg::bus_load : fetch_pkg::bus_none;
    assign mem_request.addr    = {pc[`FETCH_ADDR_BITS-1:3], 3'b000};   // Line aligned

    ////////////////////////////////////////////////////////////
    // Miss state machine
    ////////////////////////////////////////////////////////////

    always_comb begin
        state_next   = state;
        mem_tag_next = mem_tag;
        if (changed_addr) begin
            // Drop whatever was outstanding, its late return is ignored
            mem_tag_next = '0;
            state_next   = hit ? fetch_pkg::cache_idle : fetch_pkg::cache_requesting;
        end else begin
            case (state)
                fetch_pkg::cache_idle: begin
                    if (!hit) begin
                        state_next = fetch_pkg::cache_requesting;
                    end
                end
                fetch_pkg::cache_requesting: begin
                    if (mem_reply.grant_tag != '0) begin   // Zero while memory is busy
                        mem_tag_next = mem_reply.grant_tag;
                        state_next   = fetch_pkg::cache_waiting;
                    end
                end
                fetch_pkg::cache_waiting: begin
                    if (got_data) begin
                        mem_tag_next = '0;
                        state_next   = fetch_pkg::cache_idle;   // Hit shows next cycle
                    end
                end
                default: state_next = fetch_pkg::cache_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // State and storage
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= fetch_pkg::cache_idle;
            mem_tag    <= '0;
            last_tag   <= '1;   // All ones so the first pc looks new
            last_index <= '1;
            for (int i = 0; i < cache_lines; i++) begin
                entries[i] <= '0;
            end
        end else begin
            state      <= state_next;
            mem_tag    <= mem_tag_next;
            last_tag   <= cur_tag;
            last_index <= cur_index;
            if (got_data) begin
                entries[cur_index].data  <= mem_reply.return_data;
                entries[cur_index].tag   <= cur_tag;
                entries[cur_index].valid <= 1'b1;
            end
        end
    end

endmodule

//--- design/instr_memory.sv
// Instruction memory
// Tagged multi-cycle memory of 64-bit lines; grants a rotating nonzero
// tag per load and returns the line a fixed number of cycles later
// A preload port lets the program be written before the run

`include "fetch_defs.svh"

module instr_memory (
    input  logic                    clock,
    input  logic                    reset,
    input  fetch_pkg::mem_request_t mem_request,
    input  logic                    mem_busy,      // Data side owns the memory
    input  logic                    load_write,    // Preload strobe
    input  fetch_pkg::addr_t        load_addr,
    input  fetch_pkg::line_t        load_data,
    output fetch_pkg::mem_reply_t   mem_reply
);

    localparam int mem_lines = 1 << (`FETCH_MEM_ADDR_BITS - 3);   // 8192 lines
    localparam int latency   = `FETCH_MEM_LATENCY;

    typedef logic [`FETCH_MEM_ADDR_BITS-4:0] line_addr_t;   // Byte address 15..3

    // One transaction in flight
    typedef struct packed {
        fetch_pkg::mem_tag_t tag;       // Zero for an empty slot
        line_addr_t          line_addr;
    } stage_t;

    fetch_pkg::line_t storage [mem_lines];
    stage_t           pipe [latency];

    fetch_pkg::mem_tag_t next_tag;   // Tag handed out on the next grant
    fetch_pkg::mem_tag_t grant_tag;
    logic                grant;
    line_addr_t          req_line;
    line_addr_t          load_line;

    assign req_line  = mem_request.addr[`FETCH_MEM_ADDR_BITS-1:3];
    assign load_line = load_addr[`FETCH_MEM_ADDR_BITS-1:3];

    ////////////////////////////////////////////////////////////
    // Tag grant
    ////////////////////////////////////////////////////////////

    assign grant     = (mem_request.command == fetch_pkg::bus_load) && !mem_busy;
    assign grant_tag = grant ? next_tag : '0;   // Same cycle answer

    // Counts 1..15 and wraps past zero
    always_ff @(posedge clock) begin
        if (reset) begin
            next_tag <= fetch_pkg::mem_tag_t'(1);
        end else if (grant) begin
            if (next_tag == '1) begin
                next_tag <= fetch_pkg::mem_tag_t'(1);
            end else begin
                next_tag <= next_tag + fetch_pkg::mem_tag_t'(1);
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Latency pipeline
    ////////////////////////////////////////////////////////////

    // Shifts every cycle, one transaction per stage at most
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < latency; i++) begin
                pipe[i] <= '0;
            end
        end else begin
            pipe[0].tag       <= grant_tag;
            pipe[0].line_addr <= req_line;
            for (int i = 1; i < latency; i++) begin
                pipe[i] <= pipe[i-1];
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Storage and reply
    ////////////////////////////////////////////////////////////

    // Preload lands at the edge, no reset on the array
    always_ff @(posedge clock) begin
        if (load_write) begin
            storage[load_line] <= load_data;
        end
    end

    assign mem_reply.grant_tag   = grant_tag;
    assign mem_reply.return_tag  = pipe[latency-1].tag;        // Zero between returns
    assign mem_reply.return_data = storage[pipe[latency-1].line_addr];   // Read at exit

endmodule

//--- include/fetch_defs.svh
// Fetch path sizing
// Address widths, cache geometry, memory tag width and latency,
// and the program counter value after reset

`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Full width of a program counter
`define FETCH_ADDR_BITS 32

// Byte address bits that actually reach the instruction memory
`define FETCH_MEM_ADDR_BITS 16

// Direct-mapped cache size, one 64-bit line per entry
`define FETCH_CACHE_LINES 32

// Memory transaction tag width, tag zero is reserved for "no tag"
`define FETCH_MEM_TAG_BITS 4

// Cycles from tag grant to data return
`define FETCH_MEM_LATENCY 6

// First fetch address out of reset
`define FETCH_RESET_PC 32'h0000_0000

`endif

//--- run_sim.sh
#!/bin/sh
# Build the fetch path testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module fetch_tb -f compile.f \
    -Mdir obj_dir -o fetch_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/fetch_sim 2>&1 | tee sim.log
grep -q "^Simulation passed$" sim.log && exit 0 || exit 1

//--- test/fetch_cases.txt
# Fetch path cases, one command per line, values in hex except counts
# W line_addr data64 (upper word is addr+4) | R target | B busy_cycles | N packets
W 0000 a1000004a1000000
W 0008 a100000ca1000008
W 0010 b2000014b2000010
W 0018 c300001cc3000018
W 0040 d4000044d4000040
W 0100 e5000104e5000100
# Sequential fetch through the first two lines
N 4
# Back to the start, both lines now resident
R 0000
N 4
# Busy period stretches the miss on line 0x10
B 5
N 2
# Tag for 0x18 granted, then abandoned by a redirect
B 3
R 0040
N 2
# Abandoned line fetched again
R 0018
N 2
# 0x000 and 0x100 share index 0
R 0100
N 1
R 0000
N 1
R 0104
N 1
R 0004
N 3

//--- test/fetch_tb.sv
// Fetch path testbench
// Preloads the program from the case file during reset, then runs
// redirects, busy periods and fetch runs against a reference model
// of the memory, the program counter and the cache contents

`include "fetch_defs.svh"

module fetch_tb;

    localparam int mem_lines = 1 << (`FETCH_MEM_ADDR_BITS - 3);

    logic                     clock;
    logic                     reset;
    logic                     redirect;
    fetch_pkg::addr_t         redirect_pc;
    logic                     mem_busy;
    logic                     load_write;
    fetch_pkg::addr_t         load_addr;
    fetch_pkg::line_t         load_data;
    fetch_pkg::fetch_packet_t packet;
    logic                     packet_valid;

    // Case file contents
    fetch_pkg::addr_t write_addr [$];   // Preload lines
    fetch_pkg::line_t write_data [$];
    logic [7:0]       cmd_op [$];       // R, B or N
    int               cmd_count [$];
    fetch_pkg::addr_t cmd_target [$];

    // Reference model
    fetch_pkg::line_t ref_mem [mem_lines];
    logic             ref_valid [32];   // Lines the cache should hold
    logic [7:0]       ref_tag [32];
    fetch_pkg::addr_t expected_pc;
    fetch_pkg::addr_t stale_pc;         // Old pc that may still give one packet
    logic             stale_ok;
    int               pc_ready_cycle;   // Cycle the expected pc became current
    int               busy_start;       // Last busy period, end cycle not included
    int               busy_end;
    int               received;
    int               cycle;
    int               cycle_limit;

    fetch_top fetch_top_inst (
        .clock        (clock),
        .reset        (reset),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .mem_busy     (mem_busy),
        .load_write   (load_write),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .packet       (packet),
        .packet_valid (packet_valid)
    );

    always #2 clock = ~clock;   // Period 4

    ////////////////////////////////////////////////////////////
    // Model helpers
    ////////////////////////////////////////////////////////////

    function automatic fetch_pkg::instr_t expected_word(input fetch_pkg::addr_t addr);
        fetch_pkg::line_t line;
        line = ref_mem[addr[`FETCH_MEM_ADDR_BITS-1:3]];
        return addr[2] ? line[63:32] : line[31:0];   // Bit 2 picks the upper word
    endfunction

    // Index is bits 7..3, tag 15..8
    function automatic logic is_resident(input fetch_pkg::addr_t addr);
        return ref_valid[addr[7:3]] && (ref_tag[addr[7:3]] == addr[15:8]);
    endfunction

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at time %0t: %s (got %0h, expected %0h)",
                     $time, what, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value check failed");
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Per-cycle packet handling
    ////////////////////////////////////////////////////////////

    task automatic take_packet();
        logic [4:0] index;
        int         grant_cycle;
        index = expected_pc[7:3];
        if (stale_ok && (packet.pc === stale_pc)) begin
            // Committed before the redirect, old stream
            check_value(64'(packet.instruction), 64'(expected_word(stale_pc)),
                        "instruction of packet from before redirect");
            stale_ok = 1'b0;
        end else begin
            check_value(64'(packet.pc), 64'(expected_pc), "packet pc");
            check_value(64'(packet.instruction), 64'(expected_word(expected_pc)),
                        "packet instruction");
            if (is_resident(expected_pc)) begin   // Hit timing is fixed
                check_value(64'(cycle - pc_ready_cycle), 64'd1, "cycles from pc to hit packet");
            end else begin
                // Load goes out the cycle after the miss is seen, later while memory is busy
                grant_cycle = pc_ready_cycle + 1;
                if (grant_cycle >= busy_start && grant_cycle < busy_end) begin
                    grant_cycle = busy_end;
                end
                // Memory latency, then one cycle to fill and one to register
                check_value(64'(cycle), 64'(grant_cycle + `FETCH_MEM_LATENCY + 2),
                            "cycle of packet after a miss");
            end
            ref_valid[index] = 1'b1;
            ref_tag[index]   = expected_pc[15:8];
            expected_pc      = expected_pc + 32'd4;
            pc_ready_cycle   = cycle;             // PC advanced at this edge
            received++;
        end
    endtask

    // Inputs change 1 unit after the edge, outputs are settled by then
    task automatic next_cycle();
        @(posedge clock);
        #1;
        cycle++;
        if (cycle > cycle_limit) begin
            $display("Timeout: fetch run went past %0d cycles", cycle_limit);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end else if (packet_valid) begin
            take_packet();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Commands
    ////////////////////////////////////////////////////////////

    task automatic issue_redirect(input fetch_pkg::addr_t target);
        stale_pc       = expected_pc;   // Only this pc can still produce a packet
        stale_ok       = 1'b1;
        expected_pc    = target;
        pc_ready_cycle = cycle + 1;
        redirect       = 1'b1;
        redirect_pc    = target;
        next_cycle();
        redirect       = 1'b0;
        stale_ok       = 1'b0;
    endtask

    task automatic hold_busy(input int count);
        busy_start = cycle;             // Busy from this cycle on
        busy_end   = cycle + count;
        mem_busy   = 1'b1;
        repeat (count) next_cycle();
        mem_busy = 1'b0;
    endtask

    task automatic wait_packets(input int count);
        int target;
        target = received + count;
        while (received < target) begin
            next_cycle();
        end
    endtask

    task automatic read_cases();
        integer           fd;
        int               code;
        string            text;
        logic [7:0]       op;
        fetch_pkg::addr_t addr;
        fetch_pkg::line_t data;
        int               count;
        fd = $fopen("test/fetch_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open the case file test/fetch_cases.txt");
            $display("Simulation failed");
            $fatal(1, "no case file");
        end else begin
            while (!$feof(fd)) begin
                code = $fgets(text, fd);
                if (code > 0 && text[0] != "#" && text[0] != "\n") begin
                    code = $sscanf(text, "%c", op);
                    case (op)
                        "W": begin
                            code = $sscanf(text, "%c %h %h", op, addr, data);
                            write_addr.push_back(addr);
                            write_data.push_back(data);
                        end
                        "R": begin
                            code = $sscanf(text, "%c %h", op, addr);
                            cmd_op.push_back(op);
                            cmd_target.push_back(addr);
                            cmd_count.push_back(0);
                        end
                        "B", "N": begin
                            code = $sscanf(text, "%c %d", op, count);
                            cmd_op.push_back(op);
                            cmd_target.push_back('0);
                            cmd_count.push_back(count);
                            cycle_limit += (op == "N") ? 40 * count : count;  // Budget
                        end
                        default: begin
                            $display("Unknown command in case file: %s", text);
                            $display("Simulation failed");
                            $fatal(1, "bad case file");
                        end
                    endcase
                end
            end
            $fclose(fd);
            if (write_addr.size() > 10) begin
                $display("Case file has more preload lines than reset cycles");
                $display("Simulation failed");
                $fatal(1, "too many preload lines");
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clock          = 1'b0;
        reset          = 1'b1;
        redirect       = 1'b0;
        redirect_pc    = '0;
        mem_busy       = 1'b0;
        load_write     = 1'b0;
        load_addr      = '0;
        load_data      = '0;
        stale_pc       = '0;
        stale_ok       = 1'b0;
        expected_pc    = `FETCH_RESET_PC;
        pc_ready_cycle = 0;
        busy_start     = 0;
        busy_end       = 0;
        received       = 0;
        cycle          = 0;
        cycle_limit    = 0;
        for (int i = 0; i < 32; i++) begin
            ref_valid[i] = 1'b0;
            ref_tag[i]   = '0;
        end
        read_cases();

        // Program goes in while reset is held
        for (int i = 0; i < 10; i++) begin
            if (i < write_addr.size()) begin
                load_write = 1'b1;
                load_addr  = write_addr[i];
                load_data  = write_data[i];
                ref_mem[write_addr[i][`FETCH_MEM_ADDR_BITS-1:3]] = write_data[i];
            end else begin
                load_write = 1'b0;
            end
            @(posedge clock);
            #1;
        end
        reset      = 1'b0;
        load_write = 1'b0;
        check_value(64'(packet_valid), 64'd0, "packet valid right after reset");

        foreach (cmd_op[k]) begin
            case (cmd_op[k])
                "R":     issue_redirect(cmd_target[k]);
                "B":     hold_busy(cmd_count[k]);
                default: wait_packets(cmd_count[k]);
            endcase
        end

        $display("Simulation passed");
        $finish;
    end

endmodule
